// ==== hw/shared_fifo_pkg.sv ====
/*
 * Shared definitions for the shared dynamic multi-FIFO.
 * The default sizes are the ones the top level falls back to when not overridden.
 * Derived widths are computed inside each module and are not kept here.
 */

package shared_fifo_pkg;

  // Sticky status reported by the integrity monitor
  typedef enum logic [1:0] {
    // Pool and FIFO accounting agree
    ERR_NONE        = 2'd0,
    // Used slots differ from the sum of the FIFO counts
    ERR_COUNT       = 2'd1,
    // A slot was reclaimed while not marked used
    ERR_DOUBLE_FREE = 2'd2
  } integrity_err_e;

  // Number of logical FIFOs sharing the pool
  localparam int DEF_NUM_FIFOS = 4;

  // Slots in the shared storage pool
  localparam int DEF_DEPTH = 8;

  // Payload width of each entry
  localparam int DEF_WIDTH = 16;

endpackage : shared_fifo_pkg

// ==== hw/shared_fifo_freelist.sv ====
/*
 * Free-slot pool over a used-slot bitmap.
 * Always offers the lowest free slot; has_free is combinational from the bitmap.
 * release_mask must only name slots that are currently used.
 */

`timescale 1ns/1ps

module shared_fifo_freelist #(
  parameter int Depth = shared_fifo_pkg::DEF_DEPTH,
  localparam int AddrWidth = (Depth > 1) ? $clog2(Depth) : 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // One slot taken on an accepted push
  input  logic                 push_fire,
  // Head slots handed back by pops this cycle
  input  logic [Depth-1:0]     release_mask,
  output logic [AddrWidth-1:0] alloc_slot,
  output logic                 has_free,
  output logic [Depth-1:0]     used_mask
);

  // Bit set means the slot holds a live entry
  logic [Depth-1:0] used_q;
  logic [Depth-1:0] used_d;

  // Priority encoder, lowest free index wins
  // Scanning downward leaves the smallest index as the last assignment
  always_comb begin
    alloc_slot = '0;
    for (int i = Depth - 1; i >= 0; i--) begin
      if (!used_q[i]) begin
        alloc_slot = AddrWidth'(i);
      end
    end
  end

  // Full only when every slot is taken
  assign has_free = ~&used_q;

  // Next bitmap
  // Released slots drop out, the allocated slot comes in
  // The allocated slot is free, so it never overlaps a released one
  always_comb begin
    used_d = used_q & ~release_mask;
    if (push_fire) begin
      used_d[alloc_slot] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      used_q <= '0;
    end else begin
      used_q <= used_d;
    end
  end

  // Exported for the integrity monitor
  assign used_mask = used_q;

endmodule : shared_fifo_freelist

// ==== hw/shared_fifo_linker.sv ====
/*
 * Per-FIFO linked lists over the shared slot storage.
 * Storage is flops read combinationally, so pop_data follows the head directly.
 * push_fifo_id must be below NumFifos; alloc_slot must be free when push_fire is high.
 * A push and a pop on the same FIFO in one cycle are both handled.
 */

`timescale 1ns/1ps

module shared_fifo_linker #(
  parameter int NumFifos = shared_fifo_pkg::DEF_NUM_FIFOS,
  parameter int Depth    = shared_fifo_pkg::DEF_DEPTH,
  parameter int Width    = shared_fifo_pkg::DEF_WIDTH,
  localparam int FifoIdWidth = (NumFifos > 1) ? $clog2(NumFifos) : 1,
  localparam int AddrWidth   = (Depth > 1) ? $clog2(Depth) : 1,
  localparam int CountWidth  = $clog2(Depth + 1)
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Accepted push already qualified by the pool
  input  logic                                 push_fire,
  input  logic [FifoIdWidth-1:0]               push_fifo_id,
  input  logic [Width-1:0]                     push_data,
  // Slot granted by the pool for this push
  input  logic [AddrWidth-1:0]                 alloc_slot,
  // One pop port per logical FIFO
  output logic [NumFifos-1:0]                  pop_valid,
  input  logic [NumFifos-1:0]                  pop_ready,
  output logic [NumFifos-1:0][Width-1:0]       pop_data,
  // Head slots leaving this cycle
  output logic [Depth-1:0]                     release_mask,
  output logic [NumFifos-1:0][CountWidth-1:0]  fifo_count
);

  // Payload and next link of every slot
  logic [Width-1:0]     data_mem [Depth];
  logic [AddrWidth-1:0] next_mem [Depth];

  // List state per FIFO
  logic [AddrWidth-1:0]  head_q  [NumFifos];
  logic [AddrWidth-1:0]  tail_q  [NumFifos];
  logic [CountWidth-1:0] count_q [NumFifos];

  logic [NumFifos-1:0] pop_fire;
  logic [NumFifos-1:0] push_hit;

  // Payload and link writes
  // Linking from the tail only matters when the FIFO is not empty
  // If its only entry pops this cycle the stale link is simply never followed
  always_ff @(posedge clk) begin
    if (push_fire) begin
      data_mem[alloc_slot] <= push_data;
      if (count_q[push_fifo_id] != '0) begin
        next_mem[tail_q[push_fifo_id]] <= alloc_slot;
      end
    end
  end

  // Slots popped this cycle go back to the pool
  always_comb begin
    release_mask = '0;
    for (int f = 0; f < NumFifos; f++) begin
      if (pop_fire[f]) begin
        release_mask[head_q[f]] = 1'b1;
      end
    end
  end

  for (genvar f = 0; f < NumFifos; f++) begin : gen_fifo
    assign push_hit[f] = push_fire && (push_fifo_id == FifoIdWidth'(f));
    assign pop_fire[f] = pop_valid[f] && pop_ready[f];

    // Head entry is visible as soon as the count is non-zero
    assign pop_valid[f]  = (count_q[f] != '0);
    assign pop_data[f]   = data_mem[head_q[f]];
    assign fifo_count[f] = count_q[f];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        head_q[f]  <= '0;
        tail_q[f]  <= '0;
        count_q[f] <= '0;
      end else begin
        count_q[f] <= count_q[f] + CountWidth'(push_hit[f]) - CountWidth'(pop_fire[f]);

        // New entry always becomes the tail
        if (push_hit[f]) begin
          tail_q[f] <= alloc_slot;
        end

        if (pop_fire[f]) begin
          if (count_q[f] == CountWidth'(1)) begin
            // Last entry leaves; a same-cycle push becomes the new head
            if (push_hit[f]) begin
              head_q[f] <= alloc_slot;
            end
          end else begin
            // Follow the chain to the next entry
            head_q[f] <= next_mem[head_q[f]];
          end
        end else if (push_hit[f] && (count_q[f] == '0)) begin
          // First entry of an empty FIFO
          head_q[f] <= alloc_slot;
        end
      end
    end
  end

endmodule : shared_fifo_linker

// ==== hw/shared_fifo_integrity_mon.sv ====
/*
 * Integrity monitor for the shared slot pool.
 * Checks slot accounting against the FIFO counts and reclaims against the bitmap.
 * The first fault latches and holds until reset; later faults are not reported.
 */

`timescale 1ns/1ps

module shared_fifo_integrity_mon #(
  parameter int NumFifos = shared_fifo_pkg::DEF_NUM_FIFOS,
  parameter int Depth    = shared_fifo_pkg::DEF_DEPTH,
  localparam int CountWidth = $clog2(Depth + 1),
  localparam int SumWidth   = $clog2(NumFifos * Depth + 1)
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [Depth-1:0]                    used_mask,
  input  logic [Depth-1:0]                    release_mask,
  input  logic [NumFifos-1:0][CountWidth-1:0] fifo_count,
  output shared_fifo_pkg::integrity_err_e     integrity_err
);

  logic [SumWidth-1:0] used_total;
  logic [SumWidth-1:0] count_total;
  logic                count_bad;
  logic                double_free;

  shared_fifo_pkg::integrity_err_e err_q;

  // Population count of the pool bitmap
  always_comb begin
    used_total = '0;
    for (int i = 0; i < Depth; i++) begin
      used_total = used_total + SumWidth'(used_mask[i]);
    end
  end

  // Entries the linker believes it holds
  always_comb begin
    count_total = '0;
    for (int f = 0; f < NumFifos; f++) begin
      count_total = count_total + SumWidth'(fifo_count[f]);
    end
  end

  assign count_bad = (used_total != count_total);

  // Reclaiming a slot the pool thinks is free
  assign double_free = |(release_mask & ~used_mask);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= shared_fifo_pkg::ERR_NONE;
    end else if (err_q == shared_fifo_pkg::ERR_NONE) begin
      // Double free wins when both show up together
      if (double_free) begin
        err_q <= shared_fifo_pkg::ERR_DOUBLE_FREE;
      end else if (count_bad) begin
        err_q <= shared_fifo_pkg::ERR_COUNT;
      end
    end
  end

  assign integrity_err = err_q;

endmodule : shared_fifo_integrity_mon

// ==== hw/shared_fifo_top.sv ====
/*
 * Shared dynamic multi-FIFO, one push port and one pop port per logical FIFO.
 * push_fifo_id must be below NumFifos; hold push inputs stable while not ready.
 * push_ready drops only when all Depth slots are used.
 */

`timescale 1ns/1ps

module shared_fifo_top #(
  parameter int NumFifos = shared_fifo_pkg::DEF_NUM_FIFOS,
  parameter int Depth    = shared_fifo_pkg::DEF_DEPTH,
  parameter int Width    = shared_fifo_pkg::DEF_WIDTH,
  localparam int FifoIdWidth = (NumFifos > 1) ? $clog2(NumFifos) : 1,
  localparam int AddrWidth   = (Depth > 1) ? $clog2(Depth) : 1,
  localparam int CountWidth  = $clog2(Depth + 1)
) (
  input  logic                            clk,
  input  logic                            rst_n,
  // Push side
  input  logic                            push_valid,
  output logic                            push_ready,
  input  logic [Width-1:0]                push_data,
  input  logic [FifoIdWidth-1:0]          push_fifo_id,
  // Pop side, one lane per FIFO
  output logic [NumFifos-1:0]             pop_valid,
  input  logic [NumFifos-1:0]             pop_ready,
  output logic [NumFifos-1:0][Width-1:0]  pop_data,
  // Sticky accounting status
  output shared_fifo_pkg::integrity_err_e integrity_err
);

  logic                                push_fire;
  logic [AddrWidth-1:0]                alloc_slot;
  logic                                has_free;
  logic [Depth-1:0]                    used_mask;
  logic [Depth-1:0]                    release_mask;
  logic [NumFifos-1:0][CountWidth-1:0] fifo_count;

  // Ready straight from the pool state
  assign push_ready = has_free;
  assign push_fire  = push_valid & push_ready;

  shared_fifo_freelist #(
    .Depth(Depth)
  ) u_freelist (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_fire   (push_fire),
    .release_mask(release_mask),
    .alloc_slot  (alloc_slot),
    .has_free    (has_free),
    .used_mask   (used_mask)
  );

  shared_fifo_linker #(
    .NumFifos(NumFifos),
    .Depth   (Depth),
    .Width   (Width)
  ) u_linker (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_fire   (push_fire),
    .push_fifo_id(push_fifo_id),
    .push_data   (push_data),
    .alloc_slot  (alloc_slot),
    .pop_valid   (pop_valid),
    .pop_ready   (pop_ready),
    .pop_data    (pop_data),
    .release_mask(release_mask),
    .fifo_count  (fifo_count)
  );

  // Watches the pool and the linker side by side
  shared_fifo_integrity_mon #(
    .NumFifos(NumFifos),
    .Depth   (Depth)
  ) u_integrity_mon (
    .clk          (clk),
    .rst_n        (rst_n),
    .used_mask    (used_mask),
    .release_mask (release_mask),
    .fifo_count   (fifo_count),
    .integrity_err(integrity_err)
  );

endmodule : shared_fifo_top

// ==== verif/shared_fifo_tb.sv ====
/*
 * Random-stimulus testbench for the shared multi-FIFO at the default package sizes.
 * Inputs change on falling edges; a queue per FIFO models the expected pops.
 * A push that is not taken is held stable until it is accepted.
 */

`timescale 1ns/1ps

module shared_fifo_tb;

  localparam int num_fifos    = shared_fifo_pkg::DEF_NUM_FIFOS;
  localparam int depth        = shared_fifo_pkg::DEF_DEPTH;
  localparam int width        = shared_fifo_pkg::DEF_WIDTH;
  localparam int id_w         = (num_fifos > 1) ? $clog2(num_fifos) : 1;
  localparam int reset_cycles = 8;
  localparam int random_len   = 600;
  localparam int mixed_len    = 400;
  // Fill, hold, one pop, refill, idle
  localparam int fill_len     = depth + 8;
  // Worst case drain is one pop per cycle plus a held push and an idle check
  localparam int drain_len    = depth + 3;
  localparam int max_cycles   = reset_cycles + random_len + mixed_len + fill_len
                                + 3 * drain_len + 50;

  logic                            clk;
  logic                            rst_n;
  logic                            push_valid;
  logic                            push_ready;
  logic [width-1:0]                push_data;
  logic [id_w-1:0]                 push_fifo_id;
  logic [num_fifos-1:0]            pop_valid;
  logic [num_fifos-1:0]            pop_ready;
  logic [num_fifos-1:0][width-1:0] pop_data;
  shared_fifo_pkg::integrity_err_e integrity_err;

  // Expected contents with the oldest entry at the front
  logic [width-1:0] model_q [num_fifos][$];
  int               model_total;

  // Push that the source still has to hold
  logic             pend_valid;
  logic [id_w-1:0]  pend_id;
  logic [width-1:0] pend_data;

  logic [31:0] lcg_state;
  int          errors;
  int          test_errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          combo_cycles;
  int          cycles;

  shared_fifo_top #(
    .NumFifos(num_fifos),
    .Depth   (depth),
    .Width   (width)
  ) u_shared_fifo_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .push_data    (push_data),
    .push_fifo_id (push_fifo_id),
    .pop_valid    (pop_valid),
    .pop_ready    (pop_ready),
    .pop_data     (pop_data),
    .integrity_err(integrity_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog on rising edges
  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: timeout, the tests did not finish within %0d cycles", max_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  // LCG step returning the upper half since the low bits repeat too quickly
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {16'h0000, lcg_state[31:16]};
  endfunction

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("MISMATCH at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  // DUT outputs depend on state only, so they are stable at the falling edge
  task automatic check_outputs();
    for (int f = 0; f < num_fifos; f++) begin
      compare($sformatf("pop_valid[%0d]", f), 32'(pop_valid[f]),
              32'(model_q[f].size() != 0));
      if (model_q[f].size() != 0) begin
        compare($sformatf("pop_data[%0d]", f), 32'(pop_data[f]), 32'(model_q[f][0]));
      end
    end
    // Ready drops exactly when every slot is used
    compare("push_ready", 32'(push_ready), 32'(model_total < depth));
    compare("integrity_err", 32'(integrity_err), 32'(shared_fifo_pkg::ERR_NONE));
  endtask

  // One clock cycle that checks, drives, then applies the transfers at the rising edge
  task automatic step(input logic pv, input logic [id_w-1:0] pid,
                      input logic [width-1:0] pd, input logic [num_fifos-1:0] pr);
    logic                 push_take;
    logic [num_fifos-1:0] pop_take;
    int                   n_pops;
    @(negedge clk);
    check_outputs();
    push_valid   = pv;
    push_fifo_id = pid;
    push_data    = pd;
    pop_ready    = pr;
    // Transfers of this cycle as the model predicts them
    push_take = pv && (model_total < depth);
    n_pops    = 0;
    for (int f = 0; f < num_fifos; f++) begin
      pop_take[f] = pr[f] && (model_q[f].size() != 0);
      if (pop_take[f]) begin
        n_pops++;
      end
    end
    if (push_take && n_pops >= 2) begin
      combo_cycles++;
    end
    pend_valid = pv && !push_take;
    pend_id    = pid;
    pend_data  = pd;
    @(posedge clk);
    for (int f = 0; f < num_fifos; f++) begin
      if (pop_take[f]) begin
        void'(model_q[f].pop_front());
        model_total--;
      end
    end
    if (push_take) begin
      model_q[pid].push_back(pd);
      model_total++;
    end
  endtask

  task automatic random_cycle(input int push_pct, input int ready_pct);
    logic                 pv;
    logic [id_w-1:0]      pid;
    logic [width-1:0]     pd;
    logic [num_fifos-1:0] pr;
    if (pend_valid) begin
      pv  = 1'b1;
      pid = pend_id;
      pd  = pend_data;
    end else begin
      pv  = (next_rand() % 100) < push_pct;
      pid = id_w'(next_rand() % num_fifos);
      pd  = width'(next_rand());
    end
    for (int f = 0; f < num_fifos; f++) begin
      pr[f] = (next_rand() % 100) < ready_pct;
    end
    step(pv, pid, pd, pr);
  endtask

  // Pop everything, finishing any held push first, then check the empty state
  task automatic drain();
    while (model_total != 0 || pend_valid) begin
      if (pend_valid) begin
        step(1'b1, pend_id, pend_data, '1);
      end else begin
        step(1'b0, '0, '0, '1);
      end
    end
    step(1'b0, '0, '0, '0);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s finished, no errors", name);
    end else begin
      tests_failed++;
      $display("test %s finished, %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    logic [id_w-1:0]  fid;
    logic [width-1:0] held;
    rst_n        = 1'b0;
    push_valid   = 1'b0;
    push_data    = '0;
    push_fifo_id = '0;
    pop_ready    = '0;
    pend_valid   = 1'b0;
    pend_id      = '0;
    pend_data    = '0;
    lcg_state    = 32'h9f23_ada1;
    model_total  = 0;
    errors       = 0;
    test_errors  = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    combo_cycles = 0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset state
    compare("pop_valid", 32'(pop_valid), 32'd0);
    compare("push_ready", 32'(push_ready), 32'd1);
    compare("integrity_err", 32'(integrity_err), 32'(shared_fifo_pkg::ERR_NONE));
    end_test("reset");

    // Order and pop_valid over random traffic that fills the pool now and then
    repeat (random_len) random_cycle(60, 40);
    drain();
    end_test("random");

    // Fill the whole pool through one FIFO
    fid = id_w'(next_rand() % num_fifos);
    while (model_total < depth) begin
      step(1'b1, fid, width'(next_rand()), '0);
    end
    held = width'(next_rand());
    // The pool is full and the held push must wait
    repeat (4) step(1'b1, fid, held, '0);
    // One pop frees a slot while the push is still refused this cycle
    step(1'b1, fid, held, num_fifos'(1) << fid);
    // Ready is back and the held push goes in once
    step(1'b1, fid, held, '0);
    step(1'b0, '0, '0, '0);
    drain();
    end_test("fill");

    // Heavy traffic with several pops next to a push
    combo_cycles = 0;
    repeat (mixed_len) random_cycle(90, 70);
    drain();
    // Accounting after the last transfers has reached the monitor
    @(negedge clk);
    compare("integrity_err", 32'(integrity_err), 32'(shared_fifo_pkg::ERR_NONE));
    if (combo_cycles == 0) begin
      errors++;
      test_errors++;
      $display("ERROR: no cycle combined a push with pops of two or more FIFOs");
    end
    end_test("mixed");

    $display("tests: %0d run, %0d failed; checks: %0d; errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : shared_fifo_tb

// ==== shared_fifo_top.f ====
hw/shared_fifo_pkg.sv
hw/shared_fifo_freelist.sv
hw/shared_fifo_linker.sv
hw/shared_fifo_integrity_mon.sv
hw/shared_fifo_top.sv
verif/shared_fifo_tb.sv

// ==== Makefile ====
# Verilator flow for the shared dynamic multi-FIFO
# Every variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= shared_fifo_top.f
TB_TOP    ?= shared_fifo_tb
RTL_TOP   ?= shared_fifo_top
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TB_TOP)
LOG       ?= sim.log
VFLAGS    ?= --timing
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/$(SIM_BIN): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o $(SIM_BIN)

# The run passes only if the log holds the pass line
sim: $(BUILD_DIR)/$(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
